//--- Makefile
# Verilator build and run of the sampling front end testbench

TOP     ?= sampling_frontend_tb
FLIST   ?= sampling_frontend.f
LOG     ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS  ?= --binary --timing --assert -j 0
LFLAGS  ?= --lint-only --timing

VERILATOR ?= verilator

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run fails unless the log holds the pass line
run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/data_pkg.sv
`default_nettype none

package data_pkg;

   localparam int adc_wi = 16;  // raw converter word

   // a window of up to 255 full-scale samples needs 16 + 8 bits
   localparam int sum_wi = 24;

   localparam int window_count_wi = 8;  // accumulator windows per frame, saturating

   localparam int frame_seq_wi = 16;  // frame sequence number, wraps

   typedef logic signed [adc_wi-1:0] adc_sample_t;  // two's complement ADC sample

   typedef logic signed [sum_wi-1:0] sum_t;  // signed window sum

   typedef logic [window_count_wi-1:0] window_count_t;

   typedef logic [frame_seq_wi-1:0] frame_seq_t;

endpackage

`default_nettype wire

//--- logic/multi_sampler.sv
`default_nettype none

module multi_sampler (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire                               ext_trig,
   input  wire timing_pkg::sample_period_t   sample_period,
   input  wire timing_pkg::dsample_period_t  dsample0_period,
   input  wire timing_pkg::dsample_period_t  dsample1_period,
   input  wire timing_pkg::dsample_period_t  dsample2_period,
   output logic                              sample_out,
   output logic                              dsample0_stb,
   output logic                              dsample1_stb,
   output logic                              dsample2_stb
);

   timing_pkg::sample_period_t  period_r;    // period seen at the last trigger
   timing_pkg::sample_period_t  base_count;  // position within the base period
   logic                        sample_r;

   timing_pkg::dsample_period_t ds_period [timing_pkg::dsample_n];
   timing_pkg::dsample_period_t ds_count  [timing_pkg::dsample_n];

   // the base count only advances in trigger cycles, so the strobe is a fraction of that rate
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         period_r   <= '0;
         base_count <= '0;
         sample_r   <= 1'b0;
      end else begin
         sample_r <= 1'b0;
         if (ext_trig) begin
            period_r <= sample_period;
            if ((sample_period != period_r) && (base_count != '0)) begin
               base_count <= '0;  // a new period restarts the count from a clean zero
            end else if (base_count == sample_period - timing_pkg::sample_period_t'(1)) begin
               base_count <= '0;
            end else begin
               base_count <= base_count + timing_pkg::sample_period_t'(1);
            end
            sample_r <= (base_count == '0);
         end
      end
   end

   assign sample_out = sample_r;

   assign ds_period[0] = dsample0_period;
   assign ds_period[1] = dsample1_period;
   assign ds_period[2] = dsample2_period;

   // Each down-counter steps once per base sample and reloads when it reaches 1.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int k = 0; k < timing_pkg::dsample_n; k++) begin
            ds_count[k] <= timing_pkg::dsample_period_t'(1);  // first sample closes a window
         end
      end else if (sample_r) begin
         for (int k = 0; k < timing_pkg::dsample_n; k++) begin
            if (ds_count[k] == timing_pkg::dsample_period_t'(1)) begin
               ds_count[k] <= ds_period[k];
            end else begin
               ds_count[k] <= ds_count[k] - timing_pkg::dsample_period_t'(1);
            end
         end
      end
   end

   // strobes are levels, qualified by sample_out in the blocks that use them
   assign dsample0_stb = (ds_count[0] == timing_pkg::dsample_period_t'(1));
   assign dsample1_stb = (ds_count[1] == timing_pkg::dsample_period_t'(1));
   assign dsample2_stb = (ds_count[2] == timing_pkg::dsample_period_t'(1));

endmodule

`default_nettype wire

//--- logic/record_assembler.sv
`default_nettype none

module record_assembler (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         sample_out,
   input  wire                         dsample2_stb,
   input  wire                         sum_valid,
   input  wire data_pkg::sum_t         sum_out,
   input  wire                         peak_valid,
   input  wire data_pkg::adc_sample_t  peak_out,
   output logic                        record_valid,
   output data_pkg::sum_t              record_sum,
   output data_pkg::adc_sample_t       record_peak,
   output data_pkg::window_count_t     record_windows,
   output data_pkg::frame_seq_t        record_seq
);

   logic                    frame_end_d;  // frame end, one cycle late to line up with results
   data_pkg::sum_t          held_sum;
   data_pkg::adc_sample_t   held_peak;
   data_pkg::window_count_t win_cnt;      // accumulator windows seen so far in this frame

   data_pkg::sum_t          cur_sum;
   data_pkg::adc_sample_t   cur_peak;
   data_pkg::window_count_t cur_cnt;

   // results arriving with the delayed frame end belong to windows that closed on the boundary
   assign cur_sum  = sum_valid ? sum_out : held_sum;
   assign cur_peak = peak_valid ? peak_out : held_peak;
   assign cur_cnt  = (sum_valid && !(&win_cnt)) ? win_cnt + data_pkg::window_count_t'(1)
                                                : win_cnt;  // saturates at all ones

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         frame_end_d  <= 1'b0;
         held_sum     <= '0;
         held_peak    <= '0;
         win_cnt      <= '0;
         record_valid <= 1'b0;
         record_seq   <= '0;
      end else begin
         frame_end_d  <= sample_out & dsample2_stb;
         held_sum     <= cur_sum;
         held_peak    <= cur_peak;
         win_cnt      <= frame_end_d ? '0 : cur_cnt;  // count restarts for the next frame
         record_valid <= frame_end_d;
         if (record_valid) begin
            record_seq <= record_seq + data_pkg::frame_seq_t'(1);  // wraps after all ones
         end
      end
   end

   always_ff @(posedge clk) begin
      if (frame_end_d) begin
         record_sum     <= cur_sum;
         record_peak    <= cur_peak;
         record_windows <= cur_cnt;
      end
   end

endmodule

`default_nettype wire

//--- logic/sampling_frontend.sv
`default_nettype none

module sampling_frontend (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire                               ext_trig,
   input  wire timing_pkg::sample_period_t   sample_period,
   input  wire timing_pkg::dsample_period_t  dsample0_period,
   input  wire timing_pkg::dsample_period_t  dsample1_period,
   input  wire timing_pkg::dsample_period_t  dsample2_period,
   input  wire data_pkg::adc_sample_t        adc_data,
   output wire                               sample_out,
   output wire                               sum_valid,
   output wire data_pkg::sum_t               sum_out,
   output wire                               peak_valid,
   output wire data_pkg::adc_sample_t        peak_out,
   output wire                               record_valid,
   output wire data_pkg::sum_t               record_sum,
   output wire data_pkg::adc_sample_t        record_peak,
   output wire data_pkg::window_count_t      record_windows,
   output wire data_pkg::frame_seq_t         record_seq
);

   wire dsample0_stb;  // closes accumulator windows
   wire dsample1_stb;  // closes peak windows
   wire dsample2_stb;  // closes frames

   multi_sampler i_multi_sampler (
      .clk             (clk),
      .rst_n           (rst_n),
      .ext_trig        (ext_trig),
      .sample_period   (sample_period),
      .dsample0_period (dsample0_period),
      .dsample1_period (dsample1_period),
      .dsample2_period (dsample2_period),
      .sample_out      (sample_out),
      .dsample0_stb    (dsample0_stb),
      .dsample1_stb    (dsample1_stb),
      .dsample2_stb    (dsample2_stb)
   );

   window_accumulator i_window_accumulator (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_out   (sample_out),
      .dsample0_stb (dsample0_stb),
      .adc_data     (adc_data),
      .sum_valid    (sum_valid),
      .sum_out      (sum_out)
   );

   window_peak i_window_peak (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_out   (sample_out),
      .dsample1_stb (dsample1_stb),
      .adc_data     (adc_data),
      .peak_valid   (peak_valid),
      .peak_out     (peak_out)
   );

   // the assembler sees both window results in the same cycle they leave the top level
   record_assembler i_record_assembler (
      .clk            (clk),
      .rst_n          (rst_n),
      .sample_out     (sample_out),
      .dsample2_stb   (dsample2_stb),
      .sum_valid      (sum_valid),
      .sum_out        (sum_out),
      .peak_valid     (peak_valid),
      .peak_out       (peak_out),
      .record_valid   (record_valid),
      .record_sum     (record_sum),
      .record_peak    (record_peak),
      .record_windows (record_windows),
      .record_seq     (record_seq)
   );

endmodule

`default_nettype wire

//--- logic/timing_pkg.sv
`default_nettype none

package timing_pkg;

   // base period, counted in qualified trigger cycles
   localparam int sample_period_wi = 8;

   // each down-sampling period, counted in base samples
   localparam int dsample_wi = 8;

   // number of down-sampling strobes the sampler produces
   localparam int dsample_n = 3;

   typedef logic [sample_period_wi-1:0] sample_period_t;  // trigger counts per base sample

   typedef logic [dsample_wi-1:0] dsample_period_t;  // base samples per down-sampled window

endpackage

`default_nettype wire

//--- logic/window_accumulator.sv
`default_nettype none

module window_accumulator (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         sample_out,
   input  wire                         dsample0_stb,
   input  wire data_pkg::adc_sample_t  adc_data,
   output logic                        sum_valid,
   output data_pkg::sum_t              sum_out
);

   data_pkg::sum_t acc;       // running sum of the samples taken so far in this window
   data_pkg::sum_t acc_next;  // running sum including the current sample

   logic window_end;

   // size cast of a signed sample to the wider signed type sign-extends it
   assign acc_next = acc + data_pkg::sum_t'(adc_data);

   assign window_end = sample_out & dsample0_stb;  // this sample is the last of its window

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc       <= '0;
         sum_valid <= 1'b0;
      end else begin
         sum_valid <= window_end;
         if (window_end) begin
            acc <= '0;  // next sample opens a fresh window
         end else if (sample_out) begin
            acc <= acc_next;
         end
      end
   end

   // holds the sum of the last closed window until the next window end
   always_ff @(posedge clk) begin
      if (window_end) begin
         sum_out <= acc_next;
      end
   end

endmodule

`default_nettype wire

//--- logic/window_peak.sv
`default_nettype none

module window_peak (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         sample_out,
   input  wire                         dsample1_stb,
   input  wire data_pkg::adc_sample_t  adc_data,
   output logic                        peak_valid,
   output data_pkg::adc_sample_t       peak_out
);

   data_pkg::adc_sample_t max_r;     // largest sample so far in this window
   data_pkg::adc_sample_t max_next;  // largest sample including the current one
   logic                  first_r;   // next sample is the first of a window

   logic window_end;

   // the first sample replaces the old maximum, so stale values never leak across windows
   assign max_next = (first_r || (adc_data > max_r)) ? adc_data : max_r;

   assign window_end = sample_out & dsample1_stb;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         first_r    <= 1'b1;
         peak_valid <= 1'b0;
      end else begin
         peak_valid <= window_end;
         if (sample_out) begin
            first_r <= window_end;  // a closed window makes the following sample a first
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sample_out) begin
         max_r <= max_next;
      end
      if (window_end) begin
         peak_out <= max_next;
      end
   end

endmodule

`default_nettype wire

//--- sampling_frontend.f
logic/timing_pkg.sv
logic/data_pkg.sv
logic/multi_sampler.sv
logic/window_accumulator.sv
logic/window_peak.sv
logic/record_assembler.sv
logic/sampling_frontend.sv
test/sampling_frontend_props.sv
test/sampling_frontend_tb.sv

//--- test/sampling_frontend_props.sv
`default_nettype none

module sampling_frontend_props (
   input wire clk,
   input wire rst_n,
   input wire sample_out,
   input wire dsample2_stb,
   input wire sum_valid,
   input wire peak_valid,
   input wire record_valid
);

   timeunit 1ns;
   timeprecision 100ps;

   // each valid output is a single-cycle pulse
   a_sum_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      sum_valid |=> !sum_valid)
      else $error("sum_valid stayed high for more than one cycle");

   a_peak_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      peak_valid |=> !peak_valid)
      else $error("peak_valid stayed high for more than one cycle");

   a_record_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      record_valid |=> !record_valid)
      else $error("record_valid stayed high for more than one cycle");

   // a record leaves exactly two cycles after its frame end
   a_record_latency : assert property (@(posedge clk) disable iff (!rst_n)
      record_valid == $past(sample_out && dsample2_stb, 2))
      else $error("record_valid does not follow the frame end by two cycles");

   a_reset_quiet : assert property (@(posedge clk)
      !rst_n |=> !(sum_valid || peak_valid || record_valid))
      else $error("a valid output is high during reset");

endmodule

`default_nettype wire

//--- test/sampling_frontend_tb.sv
`default_nettype none

module sampling_frontend_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int num_rows   = 6;
   localparam int reset_cyc  = 10;

   // mode 0 triggers every cycle, mode 1 every second cycle and mode 2 at random
   typedef struct packed {
      timing_pkg::sample_period_t  sp;
      timing_pkg::sample_period_t  sp2;  // period used from the middle of the row on
      timing_pkg::dsample_period_t d0;
      timing_pkg::dsample_period_t d1;
      timing_pkg::dsample_period_t d2;
      logic [1:0]                  mode;
      logic                        neg;  // force all samples negative
      logic [15:0]                 cycles;
   } row_t;

   row_t rows [num_rows] = '{
      '{8'd3, 8'd3, 8'd4, 8'd3, 8'd5, 2'd0, 1'b0, 16'd120},
      '{8'd2, 8'd2, 8'd3, 8'd2, 8'd4, 2'd1, 1'b0, 16'd120},
      '{8'd4, 8'd2, 8'd3, 8'd4, 8'd6, 2'd0, 1'b0, 16'd164},
      '{8'd2, 8'd2, 8'd5, 8'd3, 8'd4, 2'd0, 1'b1, 16'd120},
      '{8'd1, 8'd1, 8'd3, 8'd5, 8'd7, 2'd0, 1'b0, 16'd150},
      '{8'd3, 8'd5, 8'd3, 8'd5, 8'd7, 2'd2, 1'b0, 16'd300}
   };
   string row_names [num_rows] = '{"rate_every", "rate_half", "period_change",
                                   "negative_peaks", "coprime", "random_trig"};

   logic clk;
   logic rst_n;
   logic ext_trig;
   timing_pkg::sample_period_t  sample_period;
   timing_pkg::dsample_period_t dsample0_period;
   timing_pkg::dsample_period_t dsample1_period;
   timing_pkg::dsample_period_t dsample2_period;
   data_pkg::adc_sample_t       adc_data;
   wire                         sample_out;
   wire                         sum_valid;
   wire                         peak_valid;
   wire                         record_valid;
   data_pkg::sum_t              sum_out;
   data_pkg::adc_sample_t       peak_out;
   data_pkg::sum_t              record_sum;
   data_pkg::adc_sample_t       record_peak;
   data_pkg::window_count_t     record_windows;
   data_pkg::frame_seq_t        record_seq;

   string       test_name;
   logic [31:0] lcg_state = 32'haeab_7265;
   int          records_seen;

   // reference model state holds the register values after each edge
   timing_pkg::sample_period_t  m_period;
   timing_pkg::sample_period_t  m_count;
   logic                        m_sample;
   timing_pkg::dsample_period_t m_ds [3];
   data_pkg::sum_t              m_acc;
   data_pkg::sum_t              m_sum;
   logic                        m_sum_v;
   data_pkg::adc_sample_t       m_max;
   data_pkg::adc_sample_t       m_peak;
   logic                        m_first;
   logic                        m_peak_v;
   logic                        m_fe_d;
   data_pkg::sum_t              m_held_sum;
   data_pkg::adc_sample_t       m_held_peak;
   data_pkg::window_count_t     m_win;
   logic                        m_rec_v;
   data_pkg::sum_t              m_rec_sum;
   data_pkg::adc_sample_t       m_rec_peak;
   data_pkg::window_count_t     m_rec_win;
   data_pkg::frame_seq_t        m_seq;

   sampling_frontend i_sampling_frontend (.*);

   bind sampling_frontend sampling_frontend_props i_sampling_frontend_props (
      .clk(clk), .rst_n(rst_n), .sample_out(sample_out), .dsample2_stb(dsample2_stb),
      .sum_valid(sum_valid), .peak_valid(peak_valid), .record_valid(record_valid)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic stop_on_failure(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         stop_on_failure($sformatf("** Error %s %s expected %0b actual %0b",
                                   test_name, what, exp, act));
      end
   endtask

   task automatic check_sum(input string what, input data_pkg::sum_t exp,
                            input data_pkg::sum_t act);
      if (act !== exp) begin
         stop_on_failure($sformatf("** Error %s %s expected %0d actual %0d",
                                   test_name, what, exp, act));
      end
   endtask

   task automatic check_peak(input string what, input data_pkg::adc_sample_t exp,
                             input data_pkg::adc_sample_t act);
      if (act !== exp) begin
         stop_on_failure($sformatf("** Error %s %s expected %0d actual %0d",
                                   test_name, what, exp, act));
      end
   endtask

   task automatic check_windows(input data_pkg::window_count_t exp,
                                input data_pkg::window_count_t act);
      if (act !== exp) begin
         stop_on_failure($sformatf("** Error %s record_windows expected %0d actual %0d",
                                   test_name, exp, act));
      end
   endtask

   task automatic check_seq(input data_pkg::frame_seq_t exp, input data_pkg::frame_seq_t act);
      if (act !== exp) begin
         stop_on_failure($sformatf("** Error %s record_seq expected %0d actual %0d",
                                   test_name, exp, act));
      end
   endtask

   // advances the model by one edge, from the inputs that were present at that edge
   task automatic model_step();
      logic                    e0;
      logic                    e1;
      logic                    fe;
      data_pkg::sum_t          cur_sum;
      data_pkg::adc_sample_t   cur_peak;
      data_pkg::adc_sample_t   max_now;
      data_pkg::window_count_t cur_win;
      e0 = m_sample && (m_ds[0] == 8'd1);
      e1 = m_sample && (m_ds[1] == 8'd1);
      fe = m_sample && (m_ds[2] == 8'd1);
      if (!rst_n) begin
         m_period = '0;
         m_count  = '0;
         m_sample = 1'b0;
         m_ds     = '{8'd1, 8'd1, 8'd1};  // the first sample closes a one-sample window
         m_acc    = '0;
         m_sum_v  = 1'b0;
         m_first  = 1'b1;
         m_peak_v = 1'b0;
         m_fe_d   = 1'b0;
         m_held_sum  = '0;
         m_held_peak = '0;
         m_win    = '0;
         m_rec_v  = 1'b0;
         m_seq    = '0;
      end else begin
         // record uses window results of the previous cycle
         cur_sum  = m_sum_v ? m_sum : m_held_sum;
         cur_peak = m_peak_v ? m_peak : m_held_peak;
         cur_win  = (m_sum_v && m_win != 8'd255) ? m_win + 8'd1 : m_win;
         if (m_rec_v) m_seq = m_seq + 16'd1;
         m_rec_v = m_fe_d;
         if (m_fe_d) begin
            m_rec_sum  = cur_sum;
            m_rec_peak = cur_peak;
            m_rec_win  = cur_win;
         end
         m_win       = m_fe_d ? '0 : cur_win;
         m_held_sum  = cur_sum;
         m_held_peak = cur_peak;
         m_fe_d      = fe;

         m_sum_v = e0;
         if (e0) begin
            m_sum = m_acc + data_pkg::sum_t'(adc_data);
            m_acc = '0;
         end else if (m_sample) begin
            m_acc = m_acc + data_pkg::sum_t'(adc_data);
         end

         max_now  = (m_first || adc_data > m_max) ? adc_data : m_max;
         m_peak_v = e1;
         if (m_sample) begin
            m_max   = max_now;
            m_first = e1;
            if (e1) m_peak = max_now;
         end

         if (m_sample) begin
            for (int k = 0; k < 3; k++) begin
               if (m_ds[k] == 8'd1) begin
                  m_ds[k] = (k == 0) ? dsample0_period : (k == 1) ? dsample1_period
                                                                  : dsample2_period;
               end else begin
                  m_ds[k] = m_ds[k] - 8'd1;
               end
            end
         end

         m_sample = ext_trig && (m_count == '0);
         if (ext_trig) begin
            if (sample_period != m_period && m_count != '0) begin
               m_count = '0;  // a changed period restarts the count
            end else begin
               m_count = timing_pkg::sample_period_t'((int'(m_count) + 1) %
                                                      int'(sample_period));
            end
            m_period = sample_period;
         end
      end
   endtask

   task automatic compare_outputs();
      check_bit("sample_out", m_sample, sample_out);
      check_bit("sum_valid", m_sum_v, sum_valid);
      check_bit("peak_valid", m_peak_v, peak_valid);
      check_bit("record_valid", m_rec_v, record_valid);
      check_seq(m_seq, record_seq);
      if (m_sum_v) check_sum("sum_out", m_sum, sum_out);
      if (m_peak_v) check_peak("peak_out", m_peak, peak_out);
      if (m_rec_v) begin
         check_sum("record_sum", m_rec_sum, record_sum);
         check_peak("record_peak", m_rec_peak, record_peak);
         check_windows(m_rec_win, record_windows);
         records_seen++;
      end
   endtask

   // outputs are settled 10 ns after the edge, and inputs change right after the checks
   task automatic run_cycle();
      @(posedge clk);
      #10;
      model_step();
      compare_outputs();
   endtask

   task automatic drive_inputs(input row_t r, input int cyc);
      lcg_state = next_random(lcg_state);
      adc_data  = lcg_state[31:16];
      if (r.neg) adc_data[15] = 1'b1;
      case (r.mode)
         2'd0:    ext_trig = 1'b1;
         2'd1:    ext_trig = cyc[0];
         default: ext_trig = lcg_state[7];
      endcase
      if (cyc == int'(r.cycles) / 2) sample_period = r.sp2;
   endtask

   initial begin
      int limit_cycles;
      limit_cycles = 0;
      for (int i = 0; i < num_rows; i++) begin
         limit_cycles += int'(rows[i].cycles) + reset_cyc + 2;
      end
      repeat (limit_cycles * 2 + 100) @(posedge clk);
      stop_on_failure("timeout, the test sequence did not finish in time");
   end

   initial begin
      rst_n           = 1'b0;
      ext_trig        = 1'b0;
      sample_period   = 8'd1;
      dsample0_period = 8'd1;
      dsample1_period = 8'd1;
      dsample2_period = 8'd1;
      adc_data        = '0;
      for (int i = 0; i < num_rows; i++) begin
         test_name       = row_names[i];
         records_seen    = 0;
         rst_n           = 1'b0;
         ext_trig        = 1'b0;
         sample_period   = rows[i].sp;
         dsample0_period = rows[i].d0;
         dsample1_period = rows[i].d1;
         dsample2_period = rows[i].d2;
         repeat (reset_cyc) run_cycle();
         rst_n = 1'b1;
         for (int cyc = 0; cyc < int'(rows[i].cycles); cyc++) begin
            drive_inputs(rows[i], cyc);
            run_cycle();
         end
         if (records_seen == 0) begin
            stop_on_failure($sformatf("test %s produced no frame records", test_name));
         end
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire
